// ==== rvPkg.sv ====
// Widths, word types, opcode, ALU function, branch condition and FSM state encodings
`default_nettype none

package rvPkg;

   // ******************************
   // Widths and base types
   // ******************************
   localparam int xlen    = 32;            // Data and address width
   localparam int regIdxW = 5;             // Register index width

   typedef logic [xlen-1:0]    wordT;      // Any data or address word
   typedef logic [regIdxW-1:0] regIdxT;    // x0 .. x31

   // Major opcodes, taken from instruction bits 6:2
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,                 // rd <- mem[rs1 + iImm]
      opAluImm = 5'b00100,                 // rd <- rs1 OP iImm
      opAuipc  = 5'b00101,                 // rd <- PC + uImm
      opStore  = 5'b01000,                 // mem[rs1 + sImm] <- rs2
      opAluReg = 5'b01100,                 // rd <- rs1 OP rs2
      opLui    = 5'b01101,                 // rd <- uImm
      opBranch = 5'b11000,                 // if (rs1 OP rs2) PC <- PC + bImm
      opJalr   = 5'b11001,                 // rd <- PC + 4, PC <- rs1 + iImm
      opJal    = 5'b11011                  // rd <- PC + 4, PC <- PC + jImm
   } rvOpcode;

   // ALU operation, funct3 of OP and OP-IMM
   typedef enum logic [2:0] {
      fnAddSub = 3'd0, fnSll = 3'd1, fnSlt = 3'd2, fnSltu = 3'd3,
      fnXor = 3'd4, fnShiftRight = 3'd5, fnOr = 3'd6, fnAnd = 3'd7
   } aluFunct;

   // Branch condition, funct3 of BRANCH
   typedef enum logic [2:0] {
      brEq = 3'd0, brNe = 3'd1, brLt = 3'd4, brGe = 3'd5, brLtu = 3'd6, brGeu = 3'd7
   } branchCond;

   // One-hot FSM states
   typedef enum logic [6:0] {
      stFetchInstr = 7'b0000001,           // memAddr valid, instruction in flight
      stWaitInstr  = 7'b0000010,           // Latch instruction once memRbusy drops
      stFetchRegs  = 7'b0000100,           // Register reads in flight
      stExecute    = 7'b0001000,           // Dispatch point
      stLoad       = 7'b0010000,           // Load address out, data in flight
      stWaitAluMem = 7'b0100000,           // Shift or memory completion
      stStore      = 7'b1000000            // Write mask active
   } cpuState;

endpackage

`default_nettype wire

// ==== coreIf.sv ====
// Interfaces decodeIf and aluIf with their modports
`timescale 1ns/1ps
`default_nettype none

// ******************************
// Decoded instruction fields
// ******************************
interface decodeIf import rvPkg::*; ();
   logic       isLoad;
   logic       isAluImm;
   logic       isAuipc;
   logic       isStore;
   logic       isAluReg;
   logic       isLui;
   logic       isBranch;
   logic       isJalr;
   logic       isJal;
   regIdxT     rd;
   regIdxT     rs1;
   regIdxT     rs2;
   logic [2:0] funct3;
   logic       altBit;                     // Instruction bit 30, SUB and SRA
   wordT       uImm;
   wordT       iImm;
   wordT       sImm;
   wordT       bImm;
   wordT       jImm;

   modport producer (output isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui, isBranch,
                     isJalr, isJal, rd, rs1, rs2, funct3, altBit, uImm, iImm, sImm, bImm,
                     jImm);
   modport consumer (input isLoad, isAluImm, isAuipc, isStore, isAluReg, isLui, isBranch,
                     isJalr, isJal, rd, rs1, rs2, funct3, altBit, uImm, iImm, sImm, bImm,
                     jImm);
endinterface

// ******************************
// ALU strobe and results
// ******************************
interface aluIf import rvPkg::*; ();
   logic aluWr;                            // Start strobe from the FSM
   wordT aluOut;                           // ALU result register
   wordT aluPlus;                          // rs1 + operand 2, also address adder
   logic aluBusy;                          // Shift still running
   logic predicate;                        // Branch taken

   modport ctrl (output aluWr, input aluOut, aluPlus, aluBusy, predicate);
   modport alu  (input aluWr, output aluOut, aluPlus, aluBusy, predicate);
endinterface

`default_nettype wire

// ==== rvDecoder.sv ====
// Instruction decoder: opcode class flags, register fields and the five immediates
`timescale 1ns/1ps
`default_nettype none

module rvDecoder import rvPkg::*; (
   input wordT       instr,                // Latched instruction word
   decodeIf.producer dec
);

   rvOpcode opcode;

   assign opcode = rvOpcode'(instr[6:2]);  // Bits 1:0 are always 11 in RV32I

   // ******************************
   // Instruction class
   // ******************************
   assign dec.isLoad   = (opcode == opLoad);
   assign dec.isAluImm = (opcode == opAluImm);
   assign dec.isAuipc  = (opcode == opAuipc);
   assign dec.isStore  = (opcode == opStore);
   assign dec.isAluReg = (opcode == opAluReg);
   assign dec.isLui    = (opcode == opLui);
   assign dec.isBranch = (opcode == opBranch);
   assign dec.isJalr   = (opcode == opJalr);
   assign dec.isJal    = (opcode == opJal);

   // Register indices and function fields
   assign dec.rd     = instr[11:7];
   assign dec.rs1    = instr[19:15];
   assign dec.rs2    = instr[24:20];
   assign dec.funct3 = instr[14:12];
   assign dec.altBit = instr[30];

   // ******************************
   // Immediates sign-extended from instr[31]
   // ******************************
   assign dec.uImm = {instr[31:12], 12'b0};                                     // LUI, AUIPC
   assign dec.iImm = {{21{instr[31]}}, instr[30:20]};                           // OP-IMM, LW, JALR
   assign dec.sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};              // SW
   assign dec.bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign dec.jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   // Only word accesses exist in this core
   // Bits 1:0 are 11 in every RV32I word but not in the unloaded latch
   always_comb begin
      if (instr[1:0] == 2'b11 && (instr[6:2] == opLoad || instr[6:2] == opStore)) begin
         assert (instr[14:12] == 3'b010)
            else $error("rvDecoder: non-word load/store, funct3=%0d", instr[14:12]);
      end
   end

endmodule

`default_nettype wire

// ==== regFile.sv ====
// Register file with 32 words, two registered read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
   input  logic   clk,
   input  regIdxT rs1,                     // Read port 1 index
   input  regIdxT rs2,                     // Read port 2 index
   input  regIdxT rd,                      // Write index
   input  logic   writeBack,               // Write enable
   input  wordT   writeBackData,
   output wordT   rs1Data,                 // Valid one cycle after rs1
   output wordT   rs2Data                  // Valid one cycle after rs2
);

   wordT regs [32];                        // Block RAM style storage

   // ******************************
   // Reads every cycle, one write
   // ******************************
   always_ff @(posedge clk) begin
      rs1Data <= (rs1 == '0) ? '0 : regs[rs1];   // x0 always reads zero
      rs2Data <= (rs2 == '0) ? '0 : regs[rs2];

      // Writes to x0 are dropped
      if (writeBack && rd != '0) begin
         regs[rd] <= writeBackData;
      end
   end

   // Read-during-write returns the old value,
   // the FSM never reads a register in the cycle it is written

endmodule

`default_nettype wire

// ==== rvAlu.sv ====
// ALU: operand select, adder, 33-bit compare, branch predicate and bit-serial shifter
`timescale 1ns/1ps
`default_nettype none

module rvAlu import rvPkg::*; (
   input  logic      clk,
   input  wordT      rs1Data,              // Operand 1, always rs1
   input  wordT      rs2Data,
   decodeIf.consumer dec,
   aluIf.alu         alu
);

   wordT            aluIn2;
   wordT            aluReg;                // Result, also the shift register
   logic [4:0]      aluShamt = '0;         // Remaining shift steps
   logic [xlen:0]   aluMinus;              // rs1 - operand 2, with borrow
   logic            lt;
   logic            ltu;
   logic            eq;
   aluFunct         fn;
   branchCond       cond;

   assign fn   = aluFunct'(dec.funct3);
   assign cond = branchCond'(dec.funct3);

   // ******************************
   // Operands and comparisons
   // ******************************
   // rs2 for OP and BRANCH, sImm for stores, iImm for OP-IMM, loads and JALR
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2Data :
                   dec.isStore                   ? dec.sImm : dec.iImm;

   assign alu.aluPlus = rs1Data + aluIn2;

   // One subtract for SUB and every compare
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1Data} + 33'd1;
   assign ltu      = aluMinus[xlen];                        // Borrow out
   assign lt       = (rs1Data[31] ^ aluIn2[31]) ? rs1Data[31] : aluMinus[xlen];
   assign eq       = (aluMinus[xlen-1:0] == '0);

   always_comb begin
      case (cond)
         brEq:    alu.predicate = eq;
         brNe:    alu.predicate = !eq;
         brLt:    alu.predicate = lt;
         brGe:    alu.predicate = !lt;
         brLtu:   alu.predicate = ltu;
         brGeu:   alu.predicate = !ltu;
         default: alu.predicate = 1'b0;    // funct3 2 and 3 are not branches
      endcase
   end

   assign alu.aluOut  = aluReg;
   assign alu.aluBusy = |aluShamt;

   // ******************************
   // Result register and shifter
   // ******************************
   always_ff @(posedge clk) begin
      if (alu.aluWr) begin
         case (fn)
            fnAddSub: aluReg <= (dec.isAluReg & dec.altBit) ? aluMinus[xlen-1:0] : alu.aluPlus;
            fnSlt:    aluReg <= {31'b0, lt};
            fnSltu:   aluReg <= {31'b0, ltu};
            fnXor:    aluReg <= rs1Data ^ aluIn2;
            fnOr:     aluReg <= rs1Data | aluIn2;
            fnAnd:    aluReg <= rs1Data & aluIn2;
            fnSll, fnShiftRight: begin
               aluReg   <= rs1Data;        // Shifted in place below
               aluShamt <= aluIn2[4:0];
            end
            default:  aluReg <= alu.aluPlus;
         endcase
      end else if (alu.aluBusy) begin
         aluShamt <= aluShamt - 5'd1;
         // altBit picks SRA over SRL
         aluReg <= (fn == fnShiftRight) ? {dec.altBit & aluReg[31], aluReg[31:1]}
                                        : {aluReg[30:0], 1'b0};
      end
   end

   // FSM must not start a new op while a shift runs
   assert property (@(posedge clk) alu.aluWr |-> !alu.aluBusy)
      else $error("rvAlu: aluWr while shift in progress");

endmodule

`default_nettype wire

// ==== rvControl.sv ====
// Control: one-hot FSM, PC, instruction latch, memory address and write-back select
`timescale 1ns/1ps
`default_nettype none

module rvControl import rvPkg::*; #(
   parameter wordT resetAddr = '0          // First fetch address
) (
   input  logic       clk,
   input  logic       reset,               // Active low, synchronous
   decodeIf.consumer  dec,
   aluIf.ctrl         alu,
   input  wordT       rs2Data,             // Store data
   output wordT       instr,               // Latched instruction
   output logic       writeBack,
   output wordT       writeBackData,
   output wordT       memAddr,
   output wordT       memWdata,
   output logic [3:0] memWmask,
   input  wordT       memRdata,
   output logic       memRstrb,
   input  logic       memRbusy,
   input  logic       memWbusy
);

   cpuState state;
   wordT    pc;
   wordT    pcPlus4;
   wordT    pcPlusImm;                     // Branch, JAL and AUIPC target
   logic    jumpToPcPlusImm;
   logic    isAlu;

   assign pcPlus4         = pc + 32'd4;
   assign pcPlusImm       = pc + (dec.isJal ? dec.jImm : dec.isAuipc ? dec.uImm : dec.bImm);
   assign jumpToPcPlusImm = dec.isJal | (dec.isBranch & alu.predicate);
   assign isAlu           = dec.isAluImm | dec.isAluReg;

   // ******************************
   // Write-back select
   // ******************************
   assign writeBackData = (dec.isLui                ? dec.uImm   : '0) |
                          (isAlu                    ? alu.aluOut : '0) |
                          (dec.isAuipc              ? pcPlusImm  : '0) |
                          ((dec.isJal | dec.isJalr) ? pcPlus4    : '0) |   // Link address
                          (dec.isLoad               ? memRdata   : '0);

   // Last cycle of stWaitAluMem carries the final value
   assign writeBack = ~(dec.isBranch | dec.isStore) &
                      ((state == stExecute) | (state == stWaitAluMem));

   assign memRstrb  = (state == stFetchInstr) | (state == stLoad);
   assign memWmask  = {4{state == stStore}};  // Word stores only
   assign memWdata  = rs2Data;
   assign alu.aluWr = (state == stExecute) & isAlu;

   // ******************************
   // State machine
   // ******************************
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= stWaitAluMem;            // Drains busy, then fetches pc
         pc    <= resetAddr;
      end else begin
         case (state)
            stFetchInstr: state <= stWaitInstr;
            stWaitInstr: begin
               if (!memRbusy) begin
                  instr <= memRdata;
                  state <= stFetchRegs;
               end
            end
            stFetchRegs: state <= stExecute;   // rs1Data/rs2Data arrive
            stExecute: begin
               pc <= dec.isJalr      ? alu.aluPlus :
                     jumpToPcPlusImm ? pcPlusImm   : pcPlus4;
               memAddr <= (dec.isJalr | dec.isLoad | dec.isStore) ? alu.aluPlus :
                          jumpToPcPlusImm                         ? pcPlusImm   : pcPlus4;
               state <= dec.isStore ? stStore :
                        dec.isLoad  ? stLoad  :
                        isAlu       ? stWaitAluMem : stFetchInstr;
            end
            stLoad, stStore: state <= stWaitAluMem;
            stWaitAluMem: begin
               if (!alu.aluBusy && !memRbusy && !memWbusy) begin
                  memAddr <= pc;           // Next fetch
                  state   <= stFetchInstr;
               end
            end
            default: state <= stWaitAluMem;    // Recover from a corrupt state
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state))
      else $error("rvControl: state not one-hot");

   // A write only happens in stStore and to a word-aligned address
   assert property (@(posedge clk) disable iff (!reset)
                    (|memWmask) |-> (state == stStore) && (memAddr[1:0] == 2'b00))
      else $error("rvControl: memWmask outside an aligned store");

endmodule

`default_nettype wire

// ==== femtoCore.sv ====
// RTL top level: decoder, register file, ALU and control joined on one memory port
`timescale 1ns/1ps
`default_nettype none

module femtoCore import rvPkg::*; #(
   parameter wordT resetAddr = '0          // Fetch address after reset
) (
   input  logic       clk,
   input  logic       reset,               // Active low
   output wordT       memAddr,             // Shared instruction/data address
   output wordT       memWdata,
   output logic [3:0] memWmask,            // All ones on a store
   input  wordT       memRdata,
   output logic       memRstrb,            // Read request pulse
   input  logic       memRbusy,
   input  logic       memWbusy
);

   decodeIf decBus ();
   aluIf    aluBus ();

   wordT instr;
   wordT rs1Data;
   wordT rs2Data;
   wordT writeBackData;
   logic writeBack;

   // ******************************
   // Datapath blocks
   // ******************************
   rvDecoder i_rvDecoder (.instr(instr), .dec(decBus));

   regFile i_regFile (
      .clk           (clk),
      .rs1           (decBus.rs1),
      .rs2           (decBus.rs2),
      .rd            (decBus.rd),
      .writeBack     (writeBack),
      .writeBackData (writeBackData),
      .rs1Data       (rs1Data),
      .rs2Data       (rs2Data)
   );

   rvAlu i_rvAlu (.clk(clk), .rs1Data(rs1Data), .rs2Data(rs2Data), .dec(decBus), .alu(aluBus));

   // Control and memory port
   rvControl #(.resetAddr(resetAddr)) i_rvControl (
      .clk(clk), .reset(reset), .dec(decBus), .alu(aluBus), .rs2Data(rs2Data),
      .instr(instr), .writeBack(writeBack), .writeBackData(writeBackData),
      .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
      .memRdata(memRdata), .memRstrb(memRstrb), .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

endmodule

`default_nettype wire

// ==== tbFemtoCore.sv ====
// Testbench for femtoCore: clock, reset, memory model, instruction encoders, directed tests
`timescale 1ns/1ps
`default_nettype none

module tbFemtoCore;

   localparam logic [31:0] resetVec   = 32'h0000_0100;   // Nonzero first fetch address
   localparam logic [31:0] resultBase = 32'h0000_0400;   // Result words, reached from x0
   localparam logic [31:0] doneAddr   = 32'h0000_07FC;   // Store here ends a program
   localparam int          maxCycles  = 20000;
   localparam int codeLoad  = 7'b0000011;
   localparam int codeImm   = 7'b0010011;
   localparam int codeAuipc = 7'b0010111;
   localparam int codeLui   = 7'b0110111;
   localparam int codeJalr  = 7'b1100111;

   logic        clk = 1'b0;
   logic        reset = 1'b0;                // Held low until the first program runs
   logic [31:0] memRdata = '0;
   logic        memRbusy = 1'b0;
   logic        memWbusy = 1'b0;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic        memRstrb;

   logic [31:0] mem [512];                   // 2 KB shared instruction/data memory
   logic [31:0] expQ [$];                    // Expected result words, in store order
   logic [31:0] aOp;
   logic [31:0] bOp;
   logic [31:0] immOp;
   integer      seed = 6;
   int          pcW;                         // Word index of the next emitted instruction
   int          errors = 0;
   int          checks = 0;
   int          timeouts = 0;
   int          busyMode = 0;
   int          busyCnt = 0;
   logic        doneSeen = 1'b0;
   logic        fetched = 1'b0;              // First fetch after reset seen
   logic        stored = 1'b0;               // First write after reset seen

   femtoCore #(.resetAddr(resetVec)) i_femtoCore (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
      .memRdata(memRdata), .memRstrb(memRstrb), .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   initial begin
      forever #20 clk = ~clk;                // 40 ns period
   end

   // ******************************
   // Memory model
   // ******************************
   always @(posedge clk) begin : memModel
      logic        req;
      logic [3:0]  mask;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        rstNow;
      req    = memRstrb;                     // Sampled at the edge
      mask   = memWmask;
      addr   = memAddr;
      wdata  = memWdata;
      rstNow = reset;
      #2;
      if (!rstNow) begin
         busyCnt = 0;
      end else begin
         if (!fetched) begin
            check({28'b0, mask}, 0, "memWmask before first fetch");
            if (req) begin
               check(addr, resetVec, "first fetch address");
               fetched = 1'b1;
            end
         end
         if (|mask) begin
            if (!stored) begin
               check(addr, resultBase, "first write address");   // First store of every program
               stored = 1'b1;
            end
            mem[addr[10:2]] = wdata;
            if (addr == doneAddr) doneSeen = 1'b1;
         end
         if (req) memRdata = mem[addr[10:2]];   // Answer on the next cycle
         if ((req || |mask) && busyMode != 0) busyCnt = $random(seed) & 3;
         else if (busyCnt > 0) busyCnt--;
      end
      memRbusy = (busyCnt != 0);
      memWbusy = (busyCnt != 0);
   end

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s, got %h, expected %h", $time, msg, got, exp);
      end
   endtask

   // ******************************
   // RV32I encoders
   // ******************************
   function automatic logic [31:0] rType(int f7, int rs2, int rs1, int f3, int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
   endfunction

   function automatic logic [31:0] iType(int imm, int rs1, int f3, int rd, int op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction

   function automatic logic [31:0] sType(int imm, int rs2, int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};   // SW
   endfunction

   function automatic logic [31:0] bType(int imm, int rs2, int rs1, int f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] uType(int imm20, int rd, int op);
      return {imm20[19:0], rd[4:0], op[6:0]};
   endfunction

   function automatic logic [31:0] jType(int imm, int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};   // JAL
   endfunction

   // ******************************
   // Program building and running
   // ******************************
   task automatic emit(input logic [31:0] word);
      mem[pcW[8:0]] = word;
      pcW++;
   endtask

   task automatic loadConst(input int rd, input logic [31:0] value);
      logic [31:0] upper;
      upper = value + 32'h800;               // Round for the sign of the ADDI part
      emit(uType(upper[31:12], rd, codeLui));
      emit(iType(value, rd, 0, rd, codeImm));
   endtask

   task automatic storeResult(input int rs, input logic [31:0] expected);
      emit(sType(resultBase + 4 * expQ.size(), rs, 0));
      expQ.push_back(expected);
   endtask

   task automatic newProgram();
      @(posedge clk);
      #2 reset = 1'b0;                       // Core idles while its memory is rewritten
      busyMode = 0;
      expQ.delete();
      for (int i = 0; i < 512; i++) begin
         mem[i[8:0]] = 32'h5A00_0000 ^ (i << 2);
      end
      pcW = resetVec >> 2;
   endtask

   task automatic runProgram(input string name);
      int n;
      emit(sType(doneAddr, 0, 0));           // Done marker
      emit(jType(0, 0));                     // Spin in place
      repeat (3) @(posedge clk);
      #2;
      doneSeen = 1'b0;
      fetched  = 1'b0;
      stored   = 1'b0;
      reset    = 1'b1;
      for (n = 0; n < maxCycles && !doneSeen; n++) @(posedge clk);
      if (!doneSeen) begin
         timeouts++;
         $display("Timeout: %s did not reach its done store in %0d cycles", name, maxCycles);
      end else begin
         for (int k = 0; k < expQ.size(); k++) begin
            check(mem[9'((resultBase >> 2) + k)], expQ[k], $sformatf("%s result %0d", name, k));
         end
      end
   endtask

   // ******************************
   // Directed tests
   // ******************************
   task automatic aluTest(input int busy, input string name);
      logic [31:0] immX;
      newProgram();
      busyMode = busy;
      immX = {{20{immOp[11]}}, immOp[11:0]};
      loadConst(1, aOp);
      loadConst(2, bOp);
      emit(rType(0, 2, 1, 0, 3));
      storeResult(3, aOp + bOp);
      emit(rType(7'h20, 2, 1, 0, 3));
      storeResult(3, aOp - bOp);
      emit(rType(0, 2, 1, 2, 3));
      storeResult(3, {31'b0, $signed(aOp) < $signed(bOp)});
      emit(rType(0, 2, 1, 3, 3));
      storeResult(3, {31'b0, aOp < bOp});
      emit(rType(0, 2, 1, 4, 3));
      storeResult(3, aOp ^ bOp);
      emit(rType(0, 2, 1, 6, 3));
      storeResult(3, aOp | bOp);
      emit(rType(0, 2, 1, 7, 3));
      storeResult(3, aOp & bOp);
      emit(iType(immOp, 1, 0, 4, codeImm));
      storeResult(4, aOp + immX);
      emit(iType(immOp, 1, 2, 4, codeImm));
      storeResult(4, {31'b0, $signed(aOp) < $signed(immX)});
      emit(iType(immOp, 1, 3, 4, codeImm));
      storeResult(4, {31'b0, aOp < immX});
      emit(iType(immOp, 1, 4, 4, codeImm));
      storeResult(4, aOp ^ immX);
      emit(iType(immOp, 1, 6, 4, codeImm));
      storeResult(4, aOp | immX);
      emit(iType(immOp, 1, 7, 4, codeImm));
      storeResult(4, aOp & immX);
      runProgram(name);
   endtask

   task automatic shiftTest();
      logic [31:0] v;
      logic [31:0] e;
      int          sh;
      int          f3;
      int          f7;
      newProgram();
      v = $random(seed) | 32'h8000_0000;     // Negative, so SRA fills ones
      loadConst(1, v);
      for (int i = 0; i < 9; i++) begin
         sh = (i < 3) ? 31 : ($random(seed) & 31);
         f3 = (i % 3 == 0) ? 1 : 5;          // SLL, SRL, SRA in turn
         f7 = (i % 3 == 2) ? 7'h20 : 0;
         case (i % 3)
            0:       e = v << sh;
            1:       e = v >> sh;
            default: e = $signed(v) >>> sh;
         endcase
         emit(iType(sh, 0, 0, 2, codeImm));  // Amount in x2
         emit(rType(f7, 2, 1, f3, 3));
         storeResult(3, e);
         emit(iType((f7 << 5) | sh, 1, f3, 4, codeImm));
         storeResult(4, e);
      end
      runProgram("shifts");
   endtask

   task automatic flowTest();
      int          opA [3] = '{5, -3, 7};
      int          opB [3] = '{5, 7, -3};
      int          conds [6] = '{0, 1, 4, 5, 6, 7};
      logic [31:0] x;
      logic [31:0] y;
      logic [31:0] at;
      logic        tk;
      newProgram();
      for (int p = 0; p < 3; p++) begin
         x = opA[p];
         y = opB[p];
         loadConst(1, x);
         loadConst(2, y);
         for (int c = 0; c < 6; c++) begin
            case (conds[c])
               0:       tk = (x == y);
               1:       tk = (x != y);
               4:       tk = ($signed(x) < $signed(y));
               5:       tk = ($signed(x) >= $signed(y));
               6:       tk = (x < y);
               default: tk = (x >= y);
            endcase
            emit(iType(1, 0, 0, 3, codeImm));
            emit(bType(8, 2, 1, conds[c]));  // Taken skips the next marker
            emit(iType(2, 0, 0, 3, codeImm));
            storeResult(3, tk ? 1 : 2);
         end
      end
      emit(iType(1, 0, 0, 6, codeImm));
      at = pcW * 4;
      emit(jType(8, 5));                     // JAL over one marker
      emit(iType(2, 0, 0, 6, codeImm));
      storeResult(6, 1);
      storeResult(5, at + 4);
      emit(iType(4, 0, 0, 6, codeImm));
      at = pcW * 4;
      emit(uType(0, 7, codeAuipc));
      emit(iType(12, 7, 0, 10, codeJalr));   // Lands at AUIPC + 12
      emit(iType(5, 0, 0, 6, codeImm));
      storeResult(6, 4);
      storeResult(10, at + 8);
      storeResult(7, at);
      at = pcW * 4;
      emit(uType(20'h12345, 8, codeAuipc));
      storeResult(8, at + 32'h1234_5000);
      runProgram("control flow");
   endtask

   task automatic loadTest();
      logic [31:0] d;
      logic [31:0] k;
      newProgram();
      d = $random(seed);
      k = $random(seed) & 32'h7FF;
      mem[384] = d;                          // Byte address 0x600
      emit(iType(12'h600, 0, 2, 11, codeLoad));
      emit(iType(k, 0, 0, 12, codeImm));
      emit(rType(0, 12, 11, 0, 13));
      storeResult(11, d);
      storeResult(13, d + k);
      emit(iType(12'h123, 0, 0, 0, codeImm));   // Writes to x0 are dropped
      emit(uType(20'hABCDE, 0, codeLui));
      emit(iType(12'h600, 0, 2, 0, codeLoad));
      emit(rType(0, 0, 0, 0, 14));
      storeResult(14, 0);
      storeResult(0, 0);
      runProgram("load and x0");
   endtask

   initial begin
      aOp   = $random(seed);
      bOp   = $random(seed);
      immOp = $random(seed);
      aluTest(0, "alu");
      shiftTest();
      flowTest();
      loadTest();
      aluTest(1, "alu with busy memory");  // Same operands, stalls added
      $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
rvPkg.sv
coreIf.sv
rvDecoder.sv
regFile.sv
rvAlu.sv
rvControl.sv
femtoCore.sv
tbFemtoCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tbFemtoCore
RTL_TOP   ?= femtoCore
RTL_SRCS  ?= rvPkg.sv coreIf.sv rvDecoder.sv regFile.sv rvAlu.sv rvControl.sv femtoCore.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
